//--- Bender.yml
package:
  name: mipsCore

sources:
  - mipsIsaPkg.sv
  - coreUarchPkg.sv
  - coreControl.sv
  - fetchUnit.sv
  - registerFile.sv
  - aluUnit.sv
  - memPort.sv
  - mipsCore.sv
  - target: test
    files:
      - mipsCore_assert.sv
      - mipsCore_tb.sv

//--- aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  mipsIsaPkg::wordT     rsData,
    input  mipsIsaPkg::wordT     rtData,
    input  mipsIsaPkg::immT      imm,
    input  coreUarchPkg::aluOpT  aluOp,
    input  logic                 immSigned,
    input  logic                 useImm,
    output mipsIsaPkg::wordT     result,
    output logic                 zero
);

    mipsIsaPkg::wordT extImm;
    mipsIsaPkg::wordT opB;

    // Sign extension for addresses, zero extension for ori
    assign extImm = immSigned ? {{16{imm[15]}}, imm} : {16'b0, imm};
    assign opB    = useImm ? extImm : rtData;

    always_comb begin
        case (aluOp)
            coreUarchPkg::AluAdd:   result = rsData + opB;
            coreUarchPkg::AluSub:   result = rsData - opB;
            coreUarchPkg::AluOr:    result = rsData | opB;
            coreUarchPkg::AluUpper: result = {imm, 16'b0};
            default:                result = '0;
        endcase
    end

    // beq compares by subtracting
    assign zero = result == '0;

endmodule

//--- coreControl.sv
`timescale 1ns/10ps

module coreControl (
    input  logic                 clk,
    input  logic                 rstN,
    input  mipsIsaPkg::wordT     instr,
    input  logic                 zero,
    input  logic                 canIssue,
    input  logic                 rspValid,
    output logic                 issueFetch,
    output logic                 issueLoad,
    output logic                 issueStore,
    output logic                 pcWrite,
    output logic                 irWrite,
    output coreUarchPkg::pcSelT  pcSel,
    output logic                 regWrite,
    output logic                 writeSel,
    output logic                 wbSel,
    output coreUarchPkg::aluOpT  aluOp,
    output logic                 immSigned,
    output logic                 useImm
);

    coreUarchPkg::ctrlStateT state;
    coreUarchPkg::ctrlStateT stateNext;
    mipsIsaPkg::opcodeT      opcode;
    mipsIsaPkg::functT       funct;
    logic isRType;
    logic isAddu;
    logic isSubu;
    logic isOri;
    logic isLui;
    logic isLw;
    logic isSw;
    logic isBeq;
    logic isJ;
    logic isAluOp;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign isRType = opcode == mipsIsaPkg::OpRType;
    assign isAddu  = isRType && (funct == mipsIsaPkg::FnAddu);
    assign isSubu  = isRType && (funct == mipsIsaPkg::FnSubu);
    assign isOri   = opcode == mipsIsaPkg::OpOri;
    assign isLui   = opcode == mipsIsaPkg::OpLui;
    assign isLw    = opcode == mipsIsaPkg::OpLw;
    assign isSw    = opcode == mipsIsaPkg::OpSw;
    assign isBeq   = opcode == mipsIsaPkg::OpBeq;
    assign isJ     = opcode == mipsIsaPkg::OpJ;
    assign isAluOp = isAddu || isSubu || isOri || isLui;

    // Operand decode, held steady for the whole instruction
    always_comb begin
        aluOp     = coreUarchPkg::AluAdd;
        useImm    = isOri || isLui || isLw || isSw;
        immSigned = isLw || isSw;
        if (isSubu || isBeq) begin
            aluOp = coreUarchPkg::AluSub;
        end else if (isOri) begin
            aluOp = coreUarchPkg::AluOr;
        end else if (isLui) begin
            aluOp = coreUarchPkg::AluUpper;
        end
    end

    assign writeSel = isOri || isLui || isLw;
    assign wbSel    = isLw;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= coreUarchPkg::StFetch;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext  = state;
        issueFetch = 1'b0;
        issueLoad  = 1'b0;
        issueStore = 1'b0;
        pcWrite    = 1'b0;
        irWrite    = 1'b0;
        pcSel      = coreUarchPkg::PcSeq;
        regWrite   = 1'b0;
        case (state)
            coreUarchPkg::StFetch: begin
                issueFetch = canIssue;
                if (canIssue) begin
                    stateNext = coreUarchPkg::StWaitInstr;
                end
            end
            coreUarchPkg::StWaitInstr: begin
                irWrite = rspValid;
                if (rspValid) begin
                    stateNext = coreUarchPkg::StDecode;
                end
            end
            coreUarchPkg::StDecode: begin
                stateNext = coreUarchPkg::StExecute;
            end
            coreUarchPkg::StExecute: begin
                if (isAluOp) begin
                    stateNext = coreUarchPkg::StWriteBack;
                end else if (isLw || isSw) begin
                    stateNext = coreUarchPkg::StMemAccess;
                end else begin
                    // beq, j and nop-like opcodes retire here
                    pcWrite   = 1'b1;
                    stateNext = coreUarchPkg::StFetch;
                    if (isJ) begin
                        pcSel = coreUarchPkg::PcJump;
                    end else if (isBeq && zero) begin
                        pcSel = coreUarchPkg::PcBranch;
                    end
                end
            end
            coreUarchPkg::StMemAccess: begin
                if (canIssue) begin
                    issueLoad  = isLw;
                    issueStore = isSw;
                    // A store retires as it issues
                    pcWrite    = isSw;
                    stateNext  = isLw ? coreUarchPkg::StWaitMem : coreUarchPkg::StFetch;
                end
            end
            coreUarchPkg::StWaitMem: begin
                if (rspValid) begin
                    stateNext = coreUarchPkg::StWriteBack;
                end
            end
            coreUarchPkg::StWriteBack: begin
                regWrite  = 1'b1;
                pcWrite   = 1'b1;
                stateNext = coreUarchPkg::StFetch;
            end
            default: begin
                stateNext = coreUarchPkg::StFetch;
            end
        endcase
    end

endmodule

//--- coreUarchPkg.sv
package coreUarchPkg;

    typedef enum logic [2:0] {
        StFetch,
        StWaitInstr,
        StDecode,
        StExecute,
        StMemAccess,
        StWaitMem,
        StWriteBack
    } ctrlStateT;

    typedef enum logic [1:0] {
        AluAdd,
        AluSub,
        AluOr,
        AluUpper
    } aluOpT;

    typedef enum logic [1:0] {
        PcSeq,
        PcBranch,
        PcJump
    } pcSelT;

    // One request per cycle on the shared bus
    typedef struct packed {
        logic              valid;
        logic              write;
        mipsIsaPkg::wordT  addr;
        mipsIsaPkg::wordT  writeData;
    } busReqT;

    // Read data only, writes are never answered
    typedef struct packed {
        logic              valid;
        mipsIsaPkg::wordT  readData;
    } busRspT;

    // Request slots buffered on the memory side
    localparam int NumCredits = 2;

    typedef logic [$clog2(NumCredits + 1)-1:0] creditCntT;

endpackage

//--- fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 pcWrite,
    input  logic                 irWrite,
    input  coreUarchPkg::pcSelT  pcSel,
    input  mipsIsaPkg::wordT     rspData,
    output mipsIsaPkg::wordT     pc,
    output mipsIsaPkg::wordT     instr
);

    mipsIsaPkg::wordT    pcPlus4;
    mipsIsaPkg::wordT    pcNext;
    mipsIsaPkg::immT     offset;
    mipsIsaPkg::jumpIdxT jumpIdx;

    assign offset  = instr[15:0];
    assign jumpIdx = instr[25:0];
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (pcSel)
            coreUarchPkg::PcBranch: pcNext = pcPlus4 + {{14{offset[15]}}, offset, 2'b00};
            coreUarchPkg::PcJump:   pcNext = {pcPlus4[31:28], jumpIdx, 2'b00};
            default:                pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc    <= mipsIsaPkg::ResetPc;
            // Decodes as nop until the first fetch returns
            instr <= '0;
        end else begin
            if (pcWrite) begin
                pc <= pcNext;
            end
            if (irWrite) begin
                instr <= rspData;
            end
        end
    end

endmodule

//--- memPort.sv
`timescale 1ns/10ps

module memPort (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  issueFetch,
    input  logic                  issueLoad,
    input  logic                  issueStore,
    input  mipsIsaPkg::wordT      pc,
    input  mipsIsaPkg::wordT      addr,
    input  mipsIsaPkg::wordT      storeData,
    output coreUarchPkg::busReqT  memReq,
    input  logic                  memCredit,
    input  coreUarchPkg::busRspT  memRsp,
    output logic                  canIssue,
    output logic                  rspValid,
    output mipsIsaPkg::wordT      rspData
);

    coreUarchPkg::creditCntT credits;
    logic issue;

    assign canIssue = credits != '0;
    assign issue    = issueFetch || issueLoad || issueStore;

    // One credit spent per issue and regained per returned pulse
    always_ff @(posedge clk) begin
        if (!rstN) begin
            credits <= coreUarchPkg::creditCntT'(coreUarchPkg::NumCredits);
        end else if (issue && !memCredit) begin
            credits <= credits - 1'b1;
        end else if (!issue && memCredit) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memReq.valid <= 1'b0;
            rspValid     <= 1'b0;
        end else begin
            memReq.valid <= issue;
            rspValid     <= memRsp.valid;
        end
        if (issue) begin
            memReq.write     <= issueStore;
            memReq.addr      <= issueFetch ? pc : addr;
            memReq.writeData <= storeData;
        end
        if (memRsp.valid) begin
            rspData <= memRsp.readData;
        end
    end

endmodule

//--- mipsCore.f
mipsIsaPkg.sv
coreUarchPkg.sv
coreControl.sv
fetchUnit.sv
registerFile.sv
aluUnit.sv
memPort.sv
mipsCore.sv
mipsCore_assert.sv
mipsCore_tb.sv

//--- mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
    input  logic                  clk,
    input  logic                  rstN,
    output coreUarchPkg::busReqT  memReq,
    input  logic                  memCredit,
    input  coreUarchPkg::busRspT  memRsp
);

    mipsIsaPkg::wordT    instr;
    mipsIsaPkg::wordT    pc;
    mipsIsaPkg::wordT    rsData;
    mipsIsaPkg::wordT    rtData;
    mipsIsaPkg::wordT    aluResult;
    mipsIsaPkg::wordT    writeData;
    mipsIsaPkg::wordT    rspData;
    mipsIsaPkg::regIdxT  rs;
    mipsIsaPkg::regIdxT  rt;
    mipsIsaPkg::regIdxT  rd;
    mipsIsaPkg::regIdxT  writeIdx;
    mipsIsaPkg::immT     imm;
    coreUarchPkg::pcSelT pcSel;
    coreUarchPkg::aluOpT aluOp;
    logic issueFetch;
    logic issueLoad;
    logic issueStore;
    logic pcWrite;
    logic irWrite;
    logic regWrite;
    logic writeSel;
    logic wbSel;
    logic immSigned;
    logic useImm;
    logic zero;
    logic canIssue;
    logic rspValid;

    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign rd  = instr[15:11];
    assign imm = instr[15:0];

    // I-type results land in rt, loads bring their data from the bus
    assign writeIdx  = writeSel ? rt : rd;
    assign writeData = wbSel ? rspData : aluResult;

    coreControl ctrl_i (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .zero       (zero),
        .canIssue   (canIssue),
        .rspValid   (rspValid),
        .issueFetch (issueFetch),
        .issueLoad  (issueLoad),
        .issueStore (issueStore),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .pcSel      (pcSel),
        .regWrite   (regWrite),
        .writeSel   (writeSel),
        .wbSel      (wbSel),
        .aluOp      (aluOp),
        .immSigned  (immSigned),
        .useImm     (useImm)
    );

    fetchUnit fetch_i (
        .clk     (clk),
        .rstN    (rstN),
        .pcWrite (pcWrite),
        .irWrite (irWrite),
        .pcSel   (pcSel),
        .rspData (rspData),
        .pc      (pc),
        .instr   (instr)
    );

    registerFile regs_i (
        .clk       (clk),
        .rstN      (rstN),
        .rs        (rs),
        .rt        (rt),
        .writeIdx  (writeIdx),
        .writeEn   (regWrite),
        .writeData (writeData),
        .rsData    (rsData),
        .rtData    (rtData)
    );

    aluUnit alu_i (
        .rsData    (rsData),
        .rtData    (rtData),
        .imm       (imm),
        .aluOp     (aluOp),
        .immSigned (immSigned),
        .useImm    (useImm),
        .result    (aluResult),
        .zero      (zero)
    );

    memPort mem_i (
        .clk        (clk),
        .rstN       (rstN),
        .issueFetch (issueFetch),
        .issueLoad  (issueLoad),
        .issueStore (issueStore),
        .pc         (pc),
        .addr       (aluResult),
        .storeData  (rtData),
        .memReq     (memReq),
        .memCredit  (memCredit),
        .memRsp     (memRsp),
        .canIssue   (canIssue),
        .rspValid   (rspValid),
        .rspData    (rspData)
    );

endmodule

//--- mipsCore_assert.sv
`timescale 1ns/10ps

module memPortAssert (
    input logic                    clk,
    input logic                    rstN,
    input coreUarchPkg::creditCntT credits,
    input coreUarchPkg::busReqT    memReq
);

    creditBound: assert property (@(posedge clk) disable iff (!rstN)
        credits <= coreUarchPkg::NumCredits)
        else $error("credit counter holds more than the memory side's slot count");

    // valid now means an issue at the previous edge
    issueNeedsCredit: assert property (@(posedge clk) disable iff (!rstN)
        memReq.valid |-> $past(credits) != '0)
        else $error("request issued while no credit was held");

    quietInReset: assert property (@(posedge clk) !rstN |=> !memReq.valid)
        else $error("request valid while reset is asserted");

endmodule

bind memPort memPortAssert assert_i (
    .clk     (clk),
    .rstN    (rstN),
    .credits (credits),
    .memReq  (memReq)
);

//--- mipsCore_tb.sv
`timescale 1ns/10ps

module mipsCore_tb;

    localparam int MemWords  = 4096;
    localparam int CodeBase  = mipsIsaPkg::ResetPc >> 2;
    // Five short programs of a few hundred cycles at most with random delays
    localparam int MaxCycles = 4000;

    logic                 clk;
    logic                 rstN;
    logic                 memCredit;
    coreUarchPkg::busReqT memReq;
    coreUarchPkg::busRspT memRsp;

    mipsIsaPkg::wordT mem [MemWords];
    logic             written [MemWords];
    mipsIsaPkg::wordT rdData [$];
    int               rdDue [$];
    mipsIsaPkg::wordT fetchLog [$];
    mipsIsaPkg::wordT haltAddr;
    logic [31:0]      rngState;
    logic             slowMode;
    int creditOwed;
    int haltHits;
    int cycle;
    int testCount;
    int checkCount;
    int errorCount;
    int testErrors;

    mipsCore dut_i (
        .clk       (clk),
        .rstN      (rstN),
        .memReq    (memReq),
        .memCredit (memCredit),
        .memRsp    (memRsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= MaxCycles) begin
            $display("Timeout: the core did not reach its halt loop within %0d cycles",
                MaxCycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int randomBelow(int n);
        rngState = nextRandom(rngState);
        return int'(rngState % n);
    endfunction

    function automatic mipsIsaPkg::wordT rType(int rs, int rt, int rd, mipsIsaPkg::functT fn);
        return {mipsIsaPkg::OpRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic mipsIsaPkg::wordT iType(mipsIsaPkg::opcodeT op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic mipsIsaPkg::wordT jump(mipsIsaPkg::wordT target);
        return {mipsIsaPkg::OpJ, target[27:2]};
    endfunction

    task automatic reportFailure(input string msg);
        errorCount++;
        testErrors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // Memory model answering reads in order after a delay with one slot per request
    always @(negedge clk) begin
        memCredit = 1'b0;
        memRsp    = '0;
        if (!rstN) begin
            rdData.delete();
            rdDue.delete();
            fetchLog.delete();
            creditOwed = 0;
            haltHits   = 0;
        end else begin
            if (memReq.valid) begin
                assert (rdData.size() + creditOwed < coreUarchPkg::NumCredits) else begin
                    reportFailure("memory side got more requests than it has slots");
                end
                if (memReq.write) begin
                    mem[memReq.addr[13:2]]     = memReq.writeData;
                    written[memReq.addr[13:2]] = 1'b1;
                    creditOwed++;
                end else begin
                    fetchLog.push_back(memReq.addr);
                    if (memReq.addr == haltAddr) begin
                        haltHits++;
                    end
                    rdData.push_back(mem[memReq.addr[13:2]]);
                    rdDue.push_back(cycle + (slowMode ? randomBelow(6) : 0));
                end
            end
            if (rdData.size() > 0 && cycle >= rdDue[0]) begin
                memRsp.valid    = 1'b1;
                memRsp.readData = rdData.pop_front();
                void'(rdDue.pop_front());
                creditOwed++;
            end
            // Credit hold-off in slow mode
            if (creditOwed > 0 && !(slowMode && randomBelow(3) == 0)) begin
                memCredit = 1'b1;
                creditOwed--;
            end
        end
    end

    task automatic startReset(input logic slow);
        @(negedge clk);
        rstN       = 1'b0;
        slowMode   = slow;
        testErrors = 0;
        for (int i = 0; i < MemWords; i++) begin
            mem[i]     = 32'ha5a5_0000 | i;
            written[i] = 1'b0;
        end
        repeat (10) @(negedge clk);
    endtask

    // Loads the code, appends a jump to itself and runs until it loops twice
    task automatic runProgram(input mipsIsaPkg::wordT code [$]);
        haltAddr = mipsIsaPkg::ResetPc + 32'(4 * code.size());
        code.push_back(jump(haltAddr));
        foreach (code[i]) begin
            mem[CodeBase + i] = code[i];
        end
        rstN = 1'b1;
        while (haltHits < 2) begin
            @(posedge clk);
        end
    endtask

    task automatic checkWord(input mipsIsaPkg::wordT addr, input mipsIsaPkg::wordT expected);
        checkCount++;
        assert (written[addr[13:2]] && mem[addr[13:2]] === expected) else begin
            reportFailure($sformatf("word at %h is %h (written %0b), expected %h",
                addr, mem[addr[13:2]], written[addr[13:2]], expected));
        end
    endtask

    task automatic checkUnwritten(input mipsIsaPkg::wordT addr);
        checkCount++;
        assert (!written[addr[13:2]]) else begin
            reportFailure($sformatf("word at %h was written but should be skipped", addr));
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %-12s done, %0d errors", name, testErrors);
    endtask

    task automatic arithTest(input logic slow, input string name);
        mipsIsaPkg::wordT code [$];
        startReset(slow);
        code = {
            iType(mipsIsaPkg::OpLui, 0, 1, 'h1234),
            iType(mipsIsaPkg::OpOri, 1, 1, 'h5678),
            iType(mipsIsaPkg::OpLui, 0, 2, 'h7654),
            iType(mipsIsaPkg::OpOri, 2, 2, 'h3210),
            rType(1, 2, 3, mipsIsaPkg::FnAddu),
            rType(1, 2, 4, mipsIsaPkg::FnSubu),
            iType(mipsIsaPkg::OpOri, 0, 0, 'h55),
            iType(mipsIsaPkg::OpSw, 0, 3, 'h100),
            iType(mipsIsaPkg::OpSw, 0, 4, 'h104),
            iType(mipsIsaPkg::OpSw, 0, 0, 'h108)
        };
        runProgram(code);
        checkWord(32'h100, 32'h8888_8888);
        checkWord(32'h104, 32'h9be0_2468);
        checkWord(32'h108, 32'h0);
        finishTest(name);
    endtask

    task automatic loadStoreTest();
        mipsIsaPkg::wordT code [$];
        startReset(1'b0);
        mem[32'h204 >> 2] = 32'h1234_5678;
        code = {
            iType(mipsIsaPkg::OpOri, 0, 5, 'h200),
            iType(mipsIsaPkg::OpLw, 5, 6, 4),
            iType(mipsIsaPkg::OpSw, 5, 6, -8)
        };
        runProgram(code);
        checkWord(32'h1f8, 32'h1234_5678);
        finishTest("loadstore");
    endtask

    task automatic branchTest();
        mipsIsaPkg::wordT code [$];
        startReset(1'b0);
        code = {
            iType(mipsIsaPkg::OpOri, 0, 1, 7),
            iType(mipsIsaPkg::OpOri, 0, 2, 7),
            iType(mipsIsaPkg::OpOri, 0, 3, 9),
            iType(mipsIsaPkg::OpOri, 0, 7, 'haaaa),
            iType(mipsIsaPkg::OpOri, 0, 8, 'hbbbb),
            iType(mipsIsaPkg::OpBeq, 1, 2, 1),
            iType(mipsIsaPkg::OpSw, 0, 7, 'h300),
            iType(mipsIsaPkg::OpBeq, 1, 3, 1),
            iType(mipsIsaPkg::OpSw, 0, 8, 'h304)
        };
        runProgram(code);
        checkUnwritten(32'h300);
        checkWord(32'h304, 32'h0000_bbbb);
        finishTest("branch");
    endtask

    task automatic jumpTest();
        mipsIsaPkg::wordT code [$];
        mipsIsaPkg::wordT jAddr;
        mipsIsaPkg::wordT target;
        int idx;
        startReset(1'b0);
        jAddr  = mipsIsaPkg::ResetPc + 32'd4;
        target = mipsIsaPkg::ResetPc + 32'd12;
        code   = {
            iType(mipsIsaPkg::OpOri, 0, 9, 'h99),
            jump(target),
            iType(mipsIsaPkg::OpSw, 0, 9, 'h400),
            iType(mipsIsaPkg::OpSw, 0, 9, 'h404)
        };
        runProgram(code);
        checkUnwritten(32'h400);
        checkWord(32'h404, 32'h0000_0099);
        // The fetch after the j goes straight to the sw at its target
        idx = -1;
        foreach (fetchLog[i]) begin
            if (idx < 0 && fetchLog[i] == jAddr) begin
                idx = i;
            end
        end
        checkCount++;
        assert (idx >= 0 && idx + 1 < fetchLog.size() && fetchLog[idx + 1] == target) else begin
            reportFailure($sformatf("fetch after the jump is not at %h", target));
        end
        finishTest("jump");
    endtask

    initial begin
        rstN      = 1'b0;
        memCredit = 1'b0;
        memRsp    = '0;
        slowMode  = 1'b0;
        rngState  = 32'h8dd2;
        haltAddr  = '1;
        arithTest(1'b0, "arithmetic");
        loadStoreTest();
        branchTest();
        jumpTest();
        arithTest(1'b1, "backpressure");
        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- mipsIsaPkg.sv
package mipsIsaPkg;

    // Machine word, also used for addresses and instructions
    typedef logic [31:0] wordT;

    typedef logic [4:0]  regIdxT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    typedef logic [15:0] immT;
    typedef logic [25:0] jumpIdxT;

    // Primary opcodes
    localparam opcodeT OpRType = 6'h00;
    localparam opcodeT OpJ     = 6'h02;
    localparam opcodeT OpBeq   = 6'h04;
    localparam opcodeT OpOri   = 6'h0d;
    localparam opcodeT OpLui   = 6'h0f;
    localparam opcodeT OpLw    = 6'h23;
    localparam opcodeT OpSw    = 6'h2b;

    // R-type function codes
    localparam functT FnAddu = 6'h21;
    localparam functT FnSubu = 6'h23;

    // Start of the code segment
    localparam wordT ResetPc = 32'h0000_3000;

endpackage

//--- registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic                clk,
    input  logic                rstN,
    input  mipsIsaPkg::regIdxT  rs,
    input  mipsIsaPkg::regIdxT  rt,
    input  mipsIsaPkg::regIdxT  writeIdx,
    input  logic                writeEn,
    input  mipsIsaPkg::wordT    writeData,
    output mipsIsaPkg::wordT    rsData,
    output mipsIsaPkg::wordT    rtData
);

    mipsIsaPkg::wordT regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeIdx != '0)) begin
            regs[writeIdx] <= writeData;
        end
    end

    // $0 never gets written, so it reads back as zero
    assign rsData = regs[rs];
    assign rtData = regs[rt];

endmodule
